//--- filelist.f
verilog/led_cmd_pkg.sv
verilog/cmd_dispatch.sv
verilog/display_settings.sv
verilog/pixel_writer.sv
verilog/panel_blanker.sv
verilog/led_cmd_top.sv
tb/led_cmd_checker.sv
tb/tb_led_cmd.sv

//--- tb/led_cmd_checker.sv
// ========================================
// Watches the DUT ports and compares RAM writes against
// a queue of expected writes and checks the settings
// ========================================
module led_cmd_checker #(
    parameter int ADDR_W = 6,
    parameter int LEVELS = 6
) (
    input  logic clk_in,
    input  logic reset,
    input  logic [2:0] rgb_enable,
    input  logic [LEVELS-1:0] brightness_enable,
    input  logic [ADDR_W-1:0] ram_address,
    input  logic [7:0] ram_data_out,
    input  logic ram_write_enable,
    input  logic busy,
    input  logic ready_for_data,
    output int write_errors,
    output int setting_errors,
    output int missing_writes
);

    logic [ADDR_W-1:0] addr_q[$];
    logic [7:0] data_q[$];
    logic ready_low_q[$];
    // a blank write that keeps ready low is followed at once by the next
    logic next_write_due;

    initial begin
        write_errors = 0;
        setting_errors = 0;
        missing_writes = 0;
        next_write_due = 1'b0;
    end

    function automatic bit values_match(input string name, input logic [15:0] expected,
                                        input logic [15:0] actual);
        if (expected !== actual) begin
            $display("ERROR at %0t: %s expected %h got %h", $time, name, expected, actual);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic expect_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data,
                                input logic ready_low);
        addr_q.push_back(addr);
        data_q.push_back(data);
        ready_low_q.push_back(ready_low);
    endtask

    // sampled mid-cycle away from the clock edge
    always @(negedge clk_in) begin
        if (!reset && next_write_due && !ram_write_enable) begin
            $display("blank sweep has a gap, no RAM write at %0t", $time);
            write_errors++;
        end
        next_write_due = 1'b0;
        if (!reset && ram_write_enable) begin
            if (addr_q.size() == 0) begin
                $display("unexpected RAM write to address %h with data %h at %0t",
                         ram_address, ram_data_out, $time);
                write_errors++;
            end else begin
                if (!values_match("ram_address", addr_q[0], ram_address)) begin
                    write_errors++;
                end
                if (!values_match("ram_data_out", data_q[0], ram_data_out)) begin
                    write_errors++;
                end
                if (ready_low_q[0] && !values_match("ready_for_data", 1'b0, ready_for_data)) begin
                    write_errors++;
                end
                if (ready_low_q[0] && !values_match("busy", 1'b1, busy)) begin
                    write_errors++;
                end
                next_write_due = ready_low_q[0];
                void'(addr_q.pop_front());
                void'(data_q.pop_front());
                void'(ready_low_q.pop_front());
            end
        end
    end

    task automatic check_settings(input logic [2:0] exp_rgb,
                                  input logic [LEVELS-1:0] exp_bright);
        if (!values_match("rgb_enable", exp_rgb, rgb_enable)) begin
            setting_errors++;
        end
        if (!values_match("brightness_enable", exp_bright, brightness_enable)) begin
            setting_errors++;
        end
        // idle front end always takes bytes
        if (!values_match("ready_for_data", 1'b1, ready_for_data)) begin
            setting_errors++;
        end
    endtask

    task automatic compare_busy(input logic exp_busy);
        if (!values_match("busy", exp_busy, busy)) begin
            setting_errors++;
        end
    endtask

    task automatic check_drained();
        if (addr_q.size() != 0) begin
            $display("%0d expected RAM writes never happened, the first to address %h",
                     addr_q.size(), addr_q[0]);
            missing_writes = addr_q.size();
        end
    endtask

endmodule

//--- tb/led_cmd_testdata.txt
# kinds: S byte | W address data | E rgb brightness, all values hex
# E is checked once busy is low, W records come before their command
E 7 3f
S 72
S 67
S 62
S 78
E 0 3f
S 52
S 42
E 5 3f
S 47
E 7 3f
S 31
S 33
S 36
E 7 16
S 30
E 7 00
S 39
S 32
S 34
S 35
E 7 29
S 54
S 15
E 7 15
W 2b a5
W 2a 3c
S 50
S 02
S 05
S a5
S 3c
E 7 15
S 5a
W 3f 81
W 3e 7e
S 50
S 03
S 07
S 81
S 7e
E 7 15

//--- tb/tb_led_cmd.sv
// ========================================
// Testbench top for the LED command front end that replays
// the stimulus file and reports the checker's counts
// ========================================
module tb_led_cmd;
    import led_cmd_pkg::*;

    localparam int PANEL_WIDTH = 8;
    localparam int PANEL_HEIGHT = 4;
    localparam int BYTES_PER_PIXEL = 2;
    localparam int LEVELS = 6;
    localparam int ADDR_W = ram_addr_bits(PANEL_WIDTH, PANEL_HEIGHT, BYTES_PER_PIXEL);
    localparam int RAM_DEPTH = PANEL_WIDTH * PANEL_HEIGHT * BYTES_PER_PIXEL;
    localparam string DATA_FILE = "tb/led_cmd_testdata.txt";

    logic clk_in;
    logic reset;
    logic [7:0] data_rx;
    logic data_ready_n;
    logic [2:0] rgb_enable;
    logic [LEVELS-1:0] brightness_enable;
    logic [ADDR_W-1:0] ram_address;
    logic [7:0] ram_data_out;
    logic ram_write_enable;
    logic busy;
    logic ready_for_data;

    int write_errors;
    int setting_errors;
    int missing_writes;
    int file_errors = 0;
    int watchdog_cycles = 0;
    logic [31:0] random_state = 32'hec29;

    led_cmd_top #(
        .PANEL_WIDTH(PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL),
        .BRIGHTNESS_LEVELS(LEVELS)
    ) dut0 (.*);

    led_cmd_checker #(
        .ADDR_W(ADDR_W),
        .LEVELS(LEVELS)
    ) checker0 (.*);

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    // LCG step with the gap taken from bits 17:16
    function automatic int next_gap();
        random_state = random_state * 32'd1103515245 + 32'd12345;
        return int'(random_state[17:16]);
    endfunction

    // skips comment lines and clears found at end of file
    task automatic read_record(input int fd, output int found, output logic [7:0] kind,
                               output logic [15:0] first, output logic [15:0] second);
        logic [8*16-1:0] token;
        logic [8*256-1:0] rest;
        int n;
        found = 0;
        kind = 8'h00;
        first = '0;
        second = '0;
        while (!found && $fscanf(fd, "%s", token) == 1) begin
            if (token == "#") begin
                n = $fgets(rest, fd);
            end else begin
                kind = token[7:0];
                if (kind == "S") begin
                    n = $fscanf(fd, "%h", first);
                end else begin
                    n = $fscanf(fd, "%h %h", first, second);
                end
                found = 1;
            end
        end
    endtask

    task automatic count_records(output int total);
        int fd;
        int found;
        logic [7:0] kind;
        logic [15:0] first;
        logic [15:0] second;
        total = 0;
        fd = $fopen(DATA_FILE, "r");
        if (fd != 0) begin
            read_record(fd, found, kind, first, second);
            while (found) begin
                total++;
                read_record(fd, found, kind, first, second);
            end
            $fclose(fd);
        end
    endtask

    // expects to start on a falling edge
    task automatic send_byte(input logic [7:0] value);
        repeat (next_gap()) @(negedge clk_in);
        while (!ready_for_data) @(negedge clk_in);
        @(posedge clk_in);
        data_rx <= value;
        data_ready_n <= 1'b0;
        @(posedge clk_in);
        data_ready_n <= 1'b1;
    endtask

    // busy has settled one edge after the byte was taken
    task automatic sample_busy(input logic exp_busy);
        @(posedge clk_in);
        @(negedge clk_in);
        checker0.compare_busy(exp_busy);
    endtask

    // a blank writes zero to every address with ready low until the last
    task automatic queue_blank_writes();
        for (int i = 0; i < RAM_DEPTH; i++) begin
            checker0.expect_write(ADDR_W'(i), 8'h00, i != RAM_DEPTH - 1);
        end
    endtask

    task automatic settle_and_check(input logic [2:0] exp_rgb,
                                    input logic [LEVELS-1:0] exp_bright);
        @(posedge clk_in);
        @(negedge clk_in);
        while (busy) @(negedge clk_in);
        checker0.check_settings(exp_rgb, exp_bright);
    endtask

    task automatic run_records(input int fd);
        int found;
        logic [7:0] kind;
        logic [15:0] first;
        logic [15:0] second;
        int args_left;
        logic exp_busy;
        args_left = 0;
        read_record(fd, found, kind, first, second);
        while (found) begin
            case (kind)
                "S": begin
                    if (args_left > 0) begin
                        // busy drops after the last argument byte
                        args_left--;
                        exp_busy = (args_left > 0);
                    end else begin
                        case (first[7:0])
                            READBRIGHTNESS: args_left = 1;
                            READPIXEL: args_left = 2 + BYTES_PER_PIXEL;
                            default: args_left = 0;
                        endcase
                        exp_busy = (args_left > 0) || (first[7:0] == BLANKPANEL);
                        if (first[7:0] == BLANKPANEL) begin
                            queue_blank_writes();
                        end
                    end
                    send_byte(first[7:0]);
                    sample_busy(exp_busy);
                end
                "W": checker0.expect_write(ADDR_W'(first), second[7:0], 1'b0);
                "E": settle_and_check(first[2:0], second[LEVELS-1:0]);
                default: begin
                    $display("stimulus file has a record of unknown kind %s", kind);
                    file_errors++;
                end
            endcase
            read_record(fd, found, kind, first, second);
        end
    endtask

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk_in);
        $display("timeout, tests still running after %0d cycles", watchdog_cycles);
        $display("Something failed");
        $finish;
    end

    initial begin
        int fd;
        int total;
        int total_errors;
        data_rx = 8'h00;
        data_ready_n = 1'b1;
        reset = 1'b1;
        count_records(total);
        watchdog_cycles = total * 80 + 200;
        repeat (16) @(posedge clk_in);
        reset <= 1'b0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("stimulus file %s could not be opened", DATA_FILE);
            file_errors++;
        end else begin
            run_records(fd);
            $fclose(fd);
        end
        @(negedge clk_in);
        checker0.check_drained();
        @(negedge clk_in);
        total_errors = write_errors + setting_errors + missing_writes + file_errors;
        $display("error counts: writes %0d, settings %0d, missing writes %0d, file %0d",
                 write_errors, setting_errors, missing_writes, file_errors);
        if (total_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verilog/cmd_dispatch.sv
// ========================================
// Byte intake, opcode decode and command FSM, also
// owns busy, ready_for_data and the RAM port mux
// ========================================
module cmd_dispatch #(
    parameter int PANEL_WIDTH = led_cmd_pkg::DEFAULT_PANEL_WIDTH,
    parameter int PANEL_HEIGHT = led_cmd_pkg::DEFAULT_PANEL_HEIGHT,
    parameter int BYTES_PER_PIXEL = led_cmd_pkg::DEFAULT_BYTES_PER_PIXEL,
    parameter int BRIGHTNESS_LEVELS = led_cmd_pkg::DEFAULT_BRIGHTNESS_LEVELS
) (
    input  logic clk_in,
    input  logic reset,
    input  logic [7:0] data_rx,
    input  logic data_ready_n,
    input  logic pix_we,
    input  logic [led_cmd_pkg::ram_addr_bits(PANEL_WIDTH, PANEL_HEIGHT,
                                             BYTES_PER_PIXEL)-1:0] pix_addr,
    input  logic [7:0] pix_data,
    input  logic pix_done,
    input  logic blank_we,
    input  logic [led_cmd_pkg::ram_addr_bits(PANEL_WIDTH, PANEL_HEIGHT,
                                             BYTES_PER_PIXEL)-1:0] blank_addr,
    input  logic blank_done,
    output logic setting_strobe,
    output led_cmd_pkg::opcode_t setting_code,
    output logic bright_load,
    output logic [BRIGHTNESS_LEVELS-1:0] bright_value,
    output logic arg_strobe,
    output logic [7:0] arg_byte,
    output logic pixel_start,
    output logic blank_start,
    output logic [led_cmd_pkg::ram_addr_bits(PANEL_WIDTH, PANEL_HEIGHT,
                                             BYTES_PER_PIXEL)-1:0] ram_address,
    output logic [7:0] ram_data_out,
    output logic ram_write_enable,
    output logic busy,
    output logic ready_for_data
);
    import led_cmd_pkg::*;

    cmd_state_t state;
    cmd_state_t next_state;
    logic [7:0] byte_reg;
    logic byte_valid;
    logic accept;
    logic cmd_done;
    logic decode_en;
    opcode_t opcode;

    assign accept = !data_ready_n && ready_for_data;
    assign opcode = opcode_t'(byte_reg);

    always_comb begin
        case (state)
            PIXEL: cmd_done = pix_done;
            BLANK: cmd_done = blank_done;
            default: cmd_done = 1'b0;
        endcase
    end

    // a byte landing on the done cycle is already a new opcode
    assign decode_en = byte_valid && (state == IDLE || cmd_done);
    assign busy = (state != IDLE) && !cmd_done;
    assign ready_for_data = (state != BLANK) || blank_done;

    assign setting_code = opcode;
    assign bright_load = byte_valid && (state == BRIGHTNESS_ARG);
    assign bright_value = BRIGHTNESS_LEVELS'(byte_reg);
    assign arg_strobe = byte_valid && (state == PIXEL) && !pix_done;
    assign arg_byte = byte_reg;

    always_comb begin
        setting_strobe = 1'b0;
        pixel_start = 1'b0;
        blank_start = 1'b0;
        next_state = state;
        if (cmd_done) begin
            next_state = IDLE;
        end
        if (bright_load) begin
            next_state = IDLE;
        end
        if (decode_en) begin
            case (opcode)
                RED_ENABLE, RED_DISABLE, GREEN_ENABLE, GREEN_DISABLE,
                BLUE_ENABLE, BLUE_DISABLE, BRIGHTNESS_ZERO, BRIGHTNESS_ONE,
                BRIGHTNESS_TWO, BRIGHTNESS_THREE, BRIGHTNESS_FOUR,
                BRIGHTNESS_FIVE, BRIGHTNESS_SIX, BRIGHTNESS_NINE: begin
                    setting_strobe = 1'b1;
                end
                READBRIGHTNESS: begin
                    next_state = BRIGHTNESS_ARG;
                end
                READPIXEL: begin
                    pixel_start = 1'b1;
                    next_state = PIXEL;
                end
                BLANKPANEL: begin
                    blank_start = 1'b1;
                    next_state = BLANK;
                end
                default: begin
                end
            endcase
        end
    end

    // RAM port follows whichever writer owns the current state
    always_comb begin
        ram_address = '0;
        ram_data_out = 8'h00;
        ram_write_enable = 1'b0;
        case (state)
            PIXEL: begin
                ram_address = pix_addr;
                ram_data_out = pix_data;
                ram_write_enable = pix_we;
            end
            BLANK: begin
                // data stays zero
                ram_address = blank_addr;
                ram_write_enable = blank_we;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= IDLE;
            byte_valid <= 1'b0;
        end else begin
            state <= next_state;
            byte_valid <= accept;
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            byte_reg <= data_rx;
        end
    end

endmodule

//--- verilog/display_settings.sv
// ========================================
// Colour plane enables and brightness mask,
// updated from the dispatcher's setting strobes
// ========================================
module display_settings #(
    parameter int BRIGHTNESS_LEVELS = led_cmd_pkg::DEFAULT_BRIGHTNESS_LEVELS
) (
    input  logic clk_in,
    input  logic reset,
    input  logic setting_strobe,
    input  led_cmd_pkg::opcode_t setting_code,
    input  logic bright_load,
    input  logic [BRIGHTNESS_LEVELS-1:0] bright_value,
    output logic [2:0] rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable
);
    import led_cmd_pkg::*;

    logic [BRIGHTNESS_LEVELS-1:0] toggle_mask;

    // opcode N flips bit LEVELS-N
    always_comb begin
        toggle_mask = '0;
        case (setting_code)
            BRIGHTNESS_ONE: toggle_mask[BRIGHTNESS_LEVELS-1] = 1'b1;
            BRIGHTNESS_TWO: toggle_mask[BRIGHTNESS_LEVELS-2] = 1'b1;
            BRIGHTNESS_THREE: toggle_mask[BRIGHTNESS_LEVELS-3] = 1'b1;
            BRIGHTNESS_FOUR: toggle_mask[BRIGHTNESS_LEVELS-4] = 1'b1;
            BRIGHTNESS_FIVE: toggle_mask[BRIGHTNESS_LEVELS-5] = 1'b1;
            BRIGHTNESS_SIX: toggle_mask[BRIGHTNESS_LEVELS-6] = 1'b1;
            default: toggle_mask = '0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_enable <= 3'b111;
            brightness_enable <= '1;
        end else if (bright_load) begin
            brightness_enable <= bright_value;
        end else if (setting_strobe) begin
            case (setting_code)
                RED_ENABLE: rgb_enable[0] <= 1'b1;
                RED_DISABLE: rgb_enable[0] <= 1'b0;
                GREEN_ENABLE: rgb_enable[1] <= 1'b1;
                GREEN_DISABLE: rgb_enable[1] <= 1'b0;
                BLUE_ENABLE: rgb_enable[2] <= 1'b1;
                BLUE_DISABLE: rgb_enable[2] <= 1'b0;
                BRIGHTNESS_ZERO: brightness_enable <= '0;
                BRIGHTNESS_NINE: brightness_enable <= '1;
                default: brightness_enable <= brightness_enable ^ toggle_mask;
            endcase
        end
    end

endmodule

//--- verilog/led_cmd_pkg.sv
// ========================================
// Shared opcodes, dispatcher states and panel geometry
// for the LED panel command front end
// ========================================
package led_cmd_pkg;

    // single-byte ASCII opcodes, any other byte is ignored
    typedef enum logic [7:0] {
        RED_ENABLE       = "R",
        RED_DISABLE      = "r",
        GREEN_ENABLE     = "G",
        GREEN_DISABLE    = "g",
        BLUE_ENABLE      = "B",
        BLUE_DISABLE     = "b",
        BRIGHTNESS_ZERO  = "0",
        BRIGHTNESS_ONE   = "1",
        BRIGHTNESS_TWO   = "2",
        BRIGHTNESS_THREE = "3",
        BRIGHTNESS_FOUR  = "4",
        BRIGHTNESS_FIVE  = "5",
        BRIGHTNESS_SIX   = "6",
        BRIGHTNESS_NINE  = "9",
        READBRIGHTNESS   = "T",
        READPIXEL        = "P",
        BLANKPANEL       = "Z"
    } opcode_t;

    typedef enum logic [1:0] {
        IDLE,
        BRIGHTNESS_ARG,
        PIXEL,
        BLANK
    } cmd_state_t;

    localparam int DEFAULT_PANEL_WIDTH = 64;
    localparam int DEFAULT_PANEL_HEIGHT = 32;
    localparam int DEFAULT_BYTES_PER_PIXEL = 2;
    localparam int DEFAULT_BRIGHTNESS_LEVELS = 6;

    function automatic int row_bits(input int height);
        return $clog2(height);
    endfunction

    function automatic int col_bits(input int width);
        return $clog2(width);
    endfunction

    function automatic int byte_sel_bits(input int bytes_per_pixel);
        return $clog2(bytes_per_pixel);
    endfunction

    // address is {row, column, byte select}
    function automatic int ram_addr_bits(input int width, input int height,
                                         input int bytes_per_pixel);
        return row_bits(height) + col_bits(width) + byte_sel_bits(bytes_per_pixel);
    endfunction

endpackage

//--- verilog/led_cmd_top.sv
// ========================================
// Command front end top level, sets the panel geometry
// and connects dispatcher, settings and RAM writers
// ========================================
module led_cmd_top #(
    parameter int PANEL_WIDTH = led_cmd_pkg::DEFAULT_PANEL_WIDTH,
    parameter int PANEL_HEIGHT = led_cmd_pkg::DEFAULT_PANEL_HEIGHT,
    parameter int BYTES_PER_PIXEL = led_cmd_pkg::DEFAULT_BYTES_PER_PIXEL,
    parameter int BRIGHTNESS_LEVELS = led_cmd_pkg::DEFAULT_BRIGHTNESS_LEVELS
) (
    input  logic clk_in,
    input  logic reset,
    input  logic [7:0] data_rx,
    input  logic data_ready_n,
    output logic [2:0] rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output logic [led_cmd_pkg::ram_addr_bits(PANEL_WIDTH, PANEL_HEIGHT,
                                             BYTES_PER_PIXEL)-1:0] ram_address,
    output logic [7:0] ram_data_out,
    output logic ram_write_enable,
    output logic busy,
    output logic ready_for_data
);
    import led_cmd_pkg::*;

    localparam int ADDR_W = ram_addr_bits(PANEL_WIDTH, PANEL_HEIGHT, BYTES_PER_PIXEL);

    logic setting_strobe;
    opcode_t setting_code;
    logic bright_load;
    logic [BRIGHTNESS_LEVELS-1:0] bright_value;
    logic arg_strobe;
    logic [7:0] arg_byte;
    logic pixel_start;
    logic pix_we;
    logic [ADDR_W-1:0] pix_addr;
    logic [7:0] pix_data;
    logic pix_done;
    logic blank_start;
    logic blank_we;
    logic [ADDR_W-1:0] blank_addr;
    logic blank_done;

    cmd_dispatch #(
        .PANEL_WIDTH(PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL),
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) dispatch0 (.*);

    display_settings #(
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) settings0 (.*);

    pixel_writer #(
        .PANEL_WIDTH(PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) pixel0 (.*);

    panel_blanker #(
        .PANEL_WIDTH(PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) blanker0 (.*);

endmodule

//--- verilog/panel_blanker.sv
// ========================================
// Frame RAM blanking, one write per cycle over
// every address, starting from zero
// ========================================
module panel_blanker #(
    parameter int PANEL_WIDTH = led_cmd_pkg::DEFAULT_PANEL_WIDTH,
    parameter int PANEL_HEIGHT = led_cmd_pkg::DEFAULT_PANEL_HEIGHT,
    parameter int BYTES_PER_PIXEL = led_cmd_pkg::DEFAULT_BYTES_PER_PIXEL
) (
    input  logic clk_in,
    input  logic reset,
    input  logic blank_start,
    output logic blank_we,
    output logic [led_cmd_pkg::ram_addr_bits(PANEL_WIDTH, PANEL_HEIGHT,
                                             BYTES_PER_PIXEL)-1:0] blank_addr,
    output logic blank_done
);
    import led_cmd_pkg::*;

    localparam int ADDR_W = ram_addr_bits(PANEL_WIDTH, PANEL_HEIGHT, BYTES_PER_PIXEL);
    // geometry is all powers of two, so the top address is all ones
    localparam logic [ADDR_W-1:0] LAST_ADDR = '1;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            blank_we <= 1'b0;
            blank_addr <= '0;
            blank_done <= 1'b0;
        end else if (blank_start) begin
            blank_we <= 1'b1;
            blank_addr <= '0;
            blank_done <= 1'b0;
        end else if (blank_done) begin
            blank_we <= 1'b0;
            blank_done <= 1'b0;
        end else if (blank_we) begin
            blank_addr <= blank_addr + 1'b1;
            // done rides along with the final write
            blank_done <= (blank_addr == LAST_ADDR - 1'b1);
        end
    end

endmodule

//--- verilog/pixel_writer.sv
// ========================================
// Single pixel command, collects row, column and
// colour bytes and issues one RAM write per colour byte
// ========================================
module pixel_writer #(
    parameter int PANEL_WIDTH = led_cmd_pkg::DEFAULT_PANEL_WIDTH,
    parameter int PANEL_HEIGHT = led_cmd_pkg::DEFAULT_PANEL_HEIGHT,
    parameter int BYTES_PER_PIXEL = led_cmd_pkg::DEFAULT_BYTES_PER_PIXEL
) (
    input  logic clk_in,
    input  logic reset,
    input  logic pixel_start,
    input  logic arg_strobe,
    input  logic [7:0] arg_byte,
    output logic pix_we,
    output logic [led_cmd_pkg::ram_addr_bits(PANEL_WIDTH, PANEL_HEIGHT,
                                             BYTES_PER_PIXEL)-1:0] pix_addr,
    output logic [7:0] pix_data,
    output logic pix_done
);
    import led_cmd_pkg::*;

    localparam int ROW_W = row_bits(PANEL_HEIGHT);
    localparam int COL_W = col_bits(PANEL_WIDTH);
    localparam int SEL_W = byte_sel_bits(BYTES_PER_PIXEL);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_ROW,
        PH_COL,
        PH_COLOUR
    } phase_t;

    phase_t phase;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    logic [SEL_W-1:0] sel;
    logic colour_strobe;

    assign colour_strobe = arg_strobe && (phase == PH_COLOUR);

    // first colour byte goes to the highest byte select
    always_ff @(posedge clk_in) begin
        if (reset) begin
            phase <= PH_IDLE;
            sel <= '0;
            pix_we <= 1'b0;
            pix_done <= 1'b0;
        end else begin
            pix_we <= colour_strobe;
            pix_done <= colour_strobe && (sel == '0);
            if (pixel_start) begin
                phase <= PH_ROW;
                sel <= '1;
            end else if (arg_strobe) begin
                case (phase)
                    PH_ROW: phase <= PH_COL;
                    PH_COL: phase <= PH_COLOUR;
                    PH_COLOUR: begin
                        sel <= sel - 1'b1;
                        if (sel == '0) begin
                            phase <= PH_IDLE;
                        end
                    end
                    default: phase <= PH_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (arg_strobe && phase == PH_ROW) begin
            row <= arg_byte[ROW_W-1:0];
        end
        if (arg_strobe && phase == PH_COL) begin
            col <= arg_byte[COL_W-1:0];
        end
        if (colour_strobe) begin
            pix_addr <= {row, col, sel};
            pix_data <= arg_byte;
        end
    end

endmodule
